// File: filelist.f
hw/n64_ctrl_pkg.sv
hw/ctrl_line_if.sv
hw/ctrl_line_timer.sv
hw/ctrl_frame_sniffer.sv
hw/ctrl_igr_collector.sv
hw/n64_ctrl_monitor.sv
sim/n64_ctrl_monitor_asserts.sv
sim/tb_n64_ctrl_monitor.sv

// File: Bender.yml
package:
  name: n64_ctrl_monitor

sources:
  - files:
      - hw/n64_ctrl_pkg.sv
      - hw/ctrl_line_if.sv
      - hw/ctrl_line_timer.sv
      - hw/ctrl_frame_sniffer.sv
      - hw/ctrl_igr_collector.sv
      - hw/n64_ctrl_monitor.sv
  - target: simulation
    files:
      - sim/n64_ctrl_monitor_asserts.sv
      - sim/tb_n64_ctrl_monitor.sv

// File: sim/tb_n64_ctrl_monitor.sv
// testbench for the joybus controller monitor
// joybus waveform tasks, reference model, compare process
// and the directed test sequence
`timescale 1ns/1ps

module tb_n64_ctrl_monitor;

  import n64_ctrl_pkg::*;

  typedef struct packed {
    ctrl_word_t data;
    port_t      port;
    logic       rst_low;  // console reset pulse expected
  } report_t;

  localparam int unsigned FRAME_CYCLES = 300 + 42 * 40;  // idle + 42 bits of 40 cycles
  localparam int unsigned WATCH_CYCLES = FRAME_CYCLES + 100;

  logic                 CTRL_CLK;
  logic                 CTRL_nRST;
  logic [NUM_PORTS-1:0] ctrl;       // joybus lines
  logic                 igr_en;
  logic                 ack;
  ctrl_word_t           data;
  port_t                port;
  logic                 new_data;
  logic                 n64_nrst;

  report_t     exp_q[$];      // reports still to come out
  int unsigned reports_seen;  // counted by the compare process
  int unsigned reports_sent;
  int          seed;
  string       test_name;

  n64_ctrl_monitor n64_ctrl_monitor_i (
    .CTRL_CLK   (CTRL_CLK),
    .CTRL_nRST  (CTRL_nRST),
    .ctrl_i     (ctrl),
    .igr_en_i   (igr_en),
    .ack_i      (ack),
    .data_o     (data),
    .port_o     (port),
    .new_data_o (new_data),
    .n64_nrst_o (n64_nrst)
  );

  initial begin
    CTRL_CLK = 1'b0;
    forever #50 CTRL_CLK = ~CTRL_CLK;  // 100 ns period
  end

  ////////////////////
  // reference and compare
  ////////////////////
  function automatic report_t expected_report(ctrl_word_t word, port_t p, logic en);
    report_t r;
    r.data    = word;  // bit i is the i-th bit on the line
    r.port    = p;
    r.rst_low = en && (word[15:0] == IGR_COMBO);
    return r;
  endfunction

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input ctrl_word_t want, input ctrl_word_t got);
    if (got !== want) begin
      $display("Error: %s %s expected %h actual %h", test_name, what, want, got);
      abort_run();
    end
  endtask

  task automatic check_port(input string what, input port_t want, input port_t got);
    if (got !== want) begin
      $display("Error: %s %s expected %0d actual %0d", test_name, what, want, got);
      abort_run();
    end
  endtask

  task automatic check_level(input string what, input logic want, input logic got);
    if (got !== want) begin
      $display("Error: %s %s expected %b actual %b", test_name, what, want, got);
      abort_run();
    end
  endtask

  // new_data rising pops one expected report
  initial begin : compare
    logic    nd_prev;
    report_t want;
    nd_prev = 1'b0;
    forever begin
      @(posedge CTRL_CLK);  // pre-edge values are stable here
      if (n64_ctrl_monitor_i.n64_ctrl_monitor_asserts_i.violations != 0) begin
        $display("A bound assertion on the monitor outputs failed.");
        abort_run();
      end
      if (new_data === 1'b1 && nd_prev !== 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("A report came out although no report was expected.");
          abort_run();
        end
        want = exp_q.pop_front();
        check_word("report data", want.data, data);
        check_port("report port", want.port, port);
        reports_seen++;
      end
      nd_prev = new_data;
    end
  end

  ////////////////////
  // joybus waveforms
  ////////////////////
  task automatic next_cycle();
    @(posedge CTRL_CLK);
    #10;  // drive and sample 10 ns after the edge
  endtask

  task automatic hold_line(input port_t p, input logic lvl, input int unsigned n);
    ctrl[p] = lvl;
    repeat (n) next_cycle();
  endtask

  task automatic send_bit(input port_t p, input logic b);
    if (b) begin
      hold_line(p, 1'b0, 10);  // short low = 1
      hold_line(p, 1'b1, 30);
    end else begin
      hold_line(p, 1'b0, 30);
      hold_line(p, 1'b1, 10);
    end
  endtask

  // resp_bits below 32 cuts the frame and leaves the line idle
  task automatic send_frame(input port_t p, input cmd_t cmd, input ctrl_word_t word,
                            input int unsigned resp_bits);
    int i;
    hold_line(p, 1'b1, 300);
    for (i = CMD_BITS - 1; i >= 0; i--)
      send_bit(p, cmd[i]);  // msb first
    send_bit(p, 1'b1);      // console stop
    for (i = 0; i < resp_bits; i++)
      send_bit(p, word[i]);
    if (resp_bits == RESP_BITS)
      send_bit(p, 1'b1);        // controller stop
    else
      hold_line(p, 1'b1, 300);  // stuck high past the gap
  endtask

  ////////////////////
  // waits
  ////////////////////
  task automatic watch_reset(input logic pulse);
    int unsigned t;
    int unsigned i;
    t = 0;
    if (pulse) begin
      while (n64_nrst !== 1'b0 && t < WATCH_CYCLES) begin
        next_cycle();
        t++;
      end
      if (n64_nrst !== 1'b0) begin
        $display("The console reset never went low after the reset combination.");
        abort_run();
      end
      for (i = 0; i < RST_HOLD_CYCLES; i++) begin  // first low cycle counts
        check_level("reset low", 1'b0, n64_nrst);
        next_cycle();
      end
      check_level("reset release", 1'b1, n64_nrst);
    end else begin
      for (i = 0; i < WATCH_CYCLES; i++) begin  // whole frame plus 100
        check_level("reset idle", 1'b1, n64_nrst);
        next_cycle();
      end
    end
  endtask

  task automatic wait_reports(input int unsigned target);
    int unsigned t;
    t = 0;
    while (reports_seen < target && t < 500) begin
      next_cycle();
      t++;
    end
    if (reports_seen < target) begin
      $display("No report came out after a complete poll frame.");
      abort_run();
    end
  endtask

  task automatic run_frame(input port_t p, input cmd_t cmd, input ctrl_word_t word,
                           input int unsigned resp_bits);
    report_t want;
    logic    reported;
    want     = expected_report(word, p, igr_en);
    reported = (cmd == POLL_CMD) && (resp_bits == RESP_BITS);
    if (reported) begin
      exp_q.push_back(want);
      reports_sent++;
    end
    fork
      send_frame(p, cmd, word, resp_bits);
      watch_reset(reported && want.rst_low);
    join
    if (reported) begin
      wait_reports(reports_sent);
      check_level("new data flag", 1'b1, new_data);
    end else begin
      check_level("no report flag", 1'b0, new_data);
    end
  endtask

  task automatic ack_report();
    ack = 1'b1;
    next_cycle();
    ack = 1'b0;
    check_level("ack clears flag", 1'b0, new_data);
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin : stimulus
    ctrl_word_t w;
    int unsigned i;
    seed         = 32'h63ecebf8;
    ctrl         = '1;  // lines idle high
    igr_en       = 1'b0;
    ack          = 1'b0;
    CTRL_nRST    = 1'b0;
    reports_seen = 0;
    reports_sent = 0;
    test_name    = "reset";
    repeat (16) @(posedge CTRL_CLK);
    #10;
    CTRL_nRST = 1'b1;
    check_level("new data", 1'b0, new_data);
    check_level("console reset", 1'b1, n64_nrst);
    check_word("data", '0, data);
    check_port("port", '0, port);

    test_name = "poll per port";
    for (i = 0; i < NUM_PORTS; i++) begin
      w = $random(seed);
      run_frame(port_t'(i), POLL_CMD, w, RESP_BITS);
      ack_report();
    end

    test_name = "ack and overwrite";
    w = $random(seed);
    run_frame(2'd1, POLL_CMD, w, RESP_BITS);
    ack_report();
    check_word("data after ack", w, data);  // flag only is cleared
    w = $random(seed);
    run_frame(2'd1, POLL_CMD, w, RESP_BITS);
    ack_report();

    test_name = "wrong command";
    w = $random(seed);
    run_frame(2'd2, 8'h00, w, RESP_BITS);

    test_name = "timeout mid response";
    w = $random(seed);
    run_frame(2'd3, POLL_CMD, w, 16);
    w = $random(seed);
    run_frame(2'd3, POLL_CMD, w, RESP_BITS);
    ack_report();

    test_name = "reset combo enabled";
    igr_en = 1'b1;
    w = $random(seed);
    w[15:0] = IGR_COMBO;
    run_frame(2'd0, POLL_CMD, w, RESP_BITS);
    ack_report();

    test_name = "reset combo disabled";
    igr_en = 1'b0;
    w = $random(seed);
    w[15:0] = IGR_COMBO;
    run_frame(2'd2, POLL_CMD, w, RESP_BITS);
    ack_report();

    test_name = "end of run";
    if (n64_ctrl_monitor_i.n64_ctrl_monitor_asserts_i.violations == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("A bound assertion on the monitor outputs failed.");
      abort_run();
    end
  end

endmodule

// File: sim/n64_ctrl_monitor_asserts.sv
// concurrent checks bound to the monitor top level
// known flag and port after reset, minimum console reset low time
`timescale 1ns/1ps

module n64_ctrl_monitor_asserts (
  input logic                CTRL_CLK,
  input logic                CTRL_nRST,
  input logic                new_data_i,
  input n64_ctrl_pkg::port_t port_i,
  input logic                n64_nrst_i
);

  import n64_ctrl_pkg::*;

  int unsigned low_len;     // consecutive low cycles of the console reset
  int unsigned violations;  // failed assertion count

  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST)
      low_len <= 0;
    else if (!n64_nrst_i)
      low_len <= low_len + 1;
    else
      low_len <= 0;  // pulse over
  end

  ////////////////////
  // output sanity
  ////////////////////
  new_data_known: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    !$isunknown(new_data_i))
    else begin
      $error("new_data_o took an unknown value");
      violations++;
    end

  port_known: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    !$isunknown(port_i))
    else begin
      $error("port_o took an unknown value");
      violations++;
    end

  // low count is sampled before it clears on the rising edge
  rst_hold_len: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_nRST)
    $rose(n64_nrst_i) |-> (low_len >= RST_HOLD_CYCLES))
    else begin
      $error("console reset low period shorter than the hold time");
      violations++;
    end

endmodule

bind n64_ctrl_monitor n64_ctrl_monitor_asserts n64_ctrl_monitor_asserts_i (
  .CTRL_CLK   (CTRL_CLK),
  .CTRL_nRST  (CTRL_nRST),
  .new_data_i (new_data_o),
  .port_i     (port_o),
  .n64_nrst_i (n64_nrst_o)
);

// File: hw/n64_ctrl_monitor.sv
// controller monitor top level
// line timer, one frame sniffer per port, report collector
`timescale 1ns/1ps

module n64_ctrl_monitor (
  input  logic                               CTRL_CLK,
  input  logic                               CTRL_nRST,
  input  logic [n64_ctrl_pkg::NUM_PORTS-1:0] ctrl_i,      // joybus lines, idle high
  input  logic                               igr_en_i,
  input  logic                               ack_i,
  output n64_ctrl_pkg::ctrl_word_t           data_o,
  output n64_ctrl_pkg::port_t                port_o,
  output logic                               new_data_o,
  output logic                               n64_nrst_o
);

  import n64_ctrl_pkg::*;

  // timer to sniffers, one bundle per port
  ctrl_line_if line_if [NUM_PORTS] ();

  // sniffers to collector
  logic [NUM_PORTS-1:0] report_valid;
  ctrl_word_t           report_data [NUM_PORTS];

  ////////////////////
  // line timing
  ////////////////////
  ctrl_line_timer ctrl_line_timer_i (
    .CTRL_CLK  (CTRL_CLK),
    .CTRL_nRST (CTRL_nRST),
    .ctrl_i    (ctrl_i),
    .line_o    (line_if)
  );

  ////////////////////
  // frame decode
  ////////////////////
  for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
    ctrl_frame_sniffer ctrl_frame_sniffer_i (
      .CTRL_CLK       (CTRL_CLK),
      .CTRL_nRST      (CTRL_nRST),
      .line_i         (line_if[g]),
      .report_valid_o (report_valid[g]),
      .report_data_o  (report_data[g])
    );
  end

  ////////////////////
  // collect and reset
  ////////////////////
  ctrl_igr_collector ctrl_igr_collector_i (
    .CTRL_CLK       (CTRL_CLK),
    .CTRL_nRST      (CTRL_nRST),
    .report_valid_i (report_valid),
    .report_data_i  (report_data),
    .igr_en_i       (igr_en_i),
    .ack_i          (ack_i),
    .data_o         (data_o),
    .port_o         (port_o),
    .new_data_o     (new_data_o),
    .n64_nrst_o     (n64_nrst_o)
  );

endmodule

// File: hw/ctrl_igr_collector.sv
// report collector and in-game reset
// lowest port wins, newest report is held with a new-data flag
// reset combination loads the console reset pulse counter
`timescale 1ns/1ps

module ctrl_igr_collector (
  input  logic                                 CTRL_CLK,
  input  logic                                 CTRL_nRST,
  input  logic [n64_ctrl_pkg::NUM_PORTS-1:0]   report_valid_i,
  input  n64_ctrl_pkg::ctrl_word_t             report_data_i [n64_ctrl_pkg::NUM_PORTS],
  input  logic                                 igr_en_i,    // in-game reset enable
  input  logic                                 ack_i,       // host read the report
  output n64_ctrl_pkg::ctrl_word_t             data_o,
  output n64_ctrl_pkg::port_t                  port_o,
  output logic                                 new_data_o,
  output logic                                 n64_nrst_o   // console reset, low active
);

  import n64_ctrl_pkg::*;

  logic       sel_valid;
  port_t      sel_port;
  ctrl_word_t sel_data;
  btn_t       sel_btn;
  logic       combo_hit;
  rst_cnt_t   rst_cnt;  // remaining low cycles after this one

  ////////////////////
  // port select
  ////////////////////
  always_comb begin
    sel_valid = 1'b0;
    sel_port  = '0;
    sel_data  = '0;
    // walk down so the lowest index is assigned last
    for (int p = NUM_PORTS - 1; p >= 0; p--) begin
      if (report_valid_i[p]) begin
        sel_valid = 1'b1;
        sel_port  = port_t'(p);
        sel_data  = report_data_i[p];
      end
    end
  end

  assign sel_btn   = sel_data[15:0];  // A B Z St D-pad, JR L R C
  assign combo_hit = sel_valid & igr_en_i & (sel_btn == IGR_COMBO);

  ////////////////////
  // report holding
  ////////////////////
  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      data_o     <= '0;
      port_o     <= '0;
      new_data_o <= 1'b0;
    end else begin
      if (sel_valid) begin
        data_o     <= sel_data;  // unread data is overwritten
        port_o     <= sel_port;
        new_data_o <= 1'b1;      // wins over ack in the same cycle
      end else if (ack_i) begin
        new_data_o <= 1'b0;
      end
    end
  end

  ////////////////////
  // reset pulse
  ////////////////////
  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      rst_cnt    <= '0;
      n64_nrst_o <= 1'b1;
    end else begin
      if (combo_hit) begin
        // first low cycle starts now, restarts while active
        rst_cnt    <= rst_cnt_t'(RST_HOLD_CYCLES - 1);
        n64_nrst_o <= 1'b0;
      end else if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - rst_cnt_t'(1);
      end else begin
        n64_nrst_o <= 1'b1;  // hold time over
      end
    end
  end

endmodule

// File: hw/ctrl_frame_sniffer.sv
// joybus frame sniffer for one port
// checks the poll command, skips the console stop bit
// and collects the 32-bit controller response
`timescale 1ns/1ps

module ctrl_frame_sniffer (
  input  logic                     CTRL_CLK,
  input  logic                     CTRL_nRST,
  ctrl_line_if.sniffer             line_i,
  output logic                     report_valid_o,  // one cycle per full response
  output n64_ctrl_pkg::ctrl_word_t report_data_o
);

  import n64_ctrl_pkg::*;

  sniff_state_t state;
  bit_cnt_t     bit_cnt;    // bits taken in the current field
  logic         seen_rise;  // line went high since the last fall
  logic         abort;
  logic         last_cmd;
  logic         last_resp;
  cmd_t         cmd_sr;     // command, msb first
  cmd_t         cmd_next;
  ctrl_word_t   resp_sr;    // response, first bit ends at bit 0

  assign cmd_next  = {cmd_sr[CMD_BITS-2:0], line_i.bit_val};
  assign last_cmd  = (bit_cnt == bit_cnt_t'(CMD_BITS - 1));
  assign last_resp = (bit_cnt == bit_cnt_t'(RESP_BITS - 1));

  // leave a frame on a stuck line or on a fall
  // without a high phase before it
  assign abort = (state != st_idle) &
                 (line_i.timeout | (line_i.fall & ~seen_rise));

  assign report_data_o = resp_sr;

  ////////////////////
  // control
  ////////////////////
  always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
    if (!CTRL_nRST) begin
      state          <= st_idle;
      bit_cnt        <= '0;
      seen_rise      <= 1'b0;
      report_valid_o <= 1'b0;
    end else begin
      report_valid_o <= 1'b0;  // strobe

      if (line_i.rise)
        seen_rise <= 1'b1;
      else if (line_i.fall)
        seen_rise <= 1'b0;

      if (abort) begin
        state <= st_idle;  // no report
      end else if (line_i.fall) begin
        case (state)
          st_idle: begin
            if (line_i.gap_ok) begin  // first command bit starts
              state   <= st_cmd;
              bit_cnt <= '0;
            end
          end
          st_cmd: begin
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
            if (last_cmd) begin
              bit_cnt <= '0;
              // only a status poll is followed
              state   <= (cmd_next == POLL_CMD) ? st_skip : st_idle;
            end
          end
          st_skip: begin
            state   <= st_resp;  // fall ends the console stop bit
            bit_cnt <= '0;
          end
          st_resp: begin
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
            if (last_resp) begin
              report_valid_o <= 1'b1;  // resp_sr is complete next cycle
              state          <= st_idle;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  ////////////////////
  // shift registers
  ////////////////////
  always_ff @(posedge CTRL_CLK) begin
    if (line_i.fall && !abort) begin
      if (state == st_cmd)
        cmd_sr <= cmd_next;
      if (state == st_resp)
        resp_sr <= {line_i.bit_val, resp_sr[RESP_BITS-1:1]};  // in from the top
    end
  end

endmodule

// File: hw/ctrl_line_timer.sv
// line timer for all controller ports
// two-flop sync, edge detection, high/low time counters
// bit decision and idle gap detection at each falling edge
`timescale 1ns/1ps

module ctrl_line_timer (
  input  logic                               CTRL_CLK,
  input  logic                               CTRL_nRST,
  input  logic [n64_ctrl_pkg::NUM_PORTS-1:0] ctrl_i,     // raw joybus lines
  ctrl_line_if.timer                         line_o [n64_ctrl_pkg::NUM_PORTS]
);

  import n64_ctrl_pkg::*;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_line

    logic [2:0] hist;      // [0],[1] sync stages, [2] previous sample
    cnt_t       high_cnt;  // cycles high since last rise
    cnt_t       low_cnt;   // cycles low since last fall
    cnt_t       low_lat;   // low time of the current bit
    logic       fall_w;
    logic       rise_w;
    logic       high_sat;
    logic       low_sat;

    // edges on the synchronized line
    assign fall_w = hist[2] & ~hist[1];
    assign rise_w = ~hist[2] & hist[1];

    assign high_sat = (high_cnt == GAP_CYCLES);
    assign low_sat  = (low_cnt == GAP_CYCLES);

    // stuck high or stuck low, frame is gone
    assign line_o[p].timeout = high_sat | low_sat;

    always_ff @(posedge CTRL_CLK or negedge CTRL_nRST) begin
      if (!CTRL_nRST) begin
        hist              <= 3'b111;  // line idles high
        high_cnt          <= '0;
        low_cnt           <= '0;
        low_lat           <= '0;
        line_o[p].fall    <= 1'b0;
        line_o[p].rise    <= 1'b0;
        line_o[p].bit_val <= 1'b0;
        line_o[p].gap_ok  <= 1'b0;
      end else begin
        hist <= {hist[1:0], ctrl_i[p]};

        // one counter runs, the other is held at zero
        if (hist[1]) begin
          if (!high_sat)
            high_cnt <= high_cnt + cnt_t'(1);
          low_cnt <= '0;
        end else begin
          if (!low_sat)
            low_cnt <= low_cnt + cnt_t'(1);
          high_cnt <= '0;
        end

        if (rise_w)
          low_lat <= low_cnt;  // keep low part for the bit decision

        // registered strobes, 3 cycles behind the pin
        line_o[p].fall    <= fall_w;
        line_o[p].rise    <= rise_w;
        line_o[p].bit_val <= fall_w & (low_lat < high_cnt);  // short low = 1
        line_o[p].gap_ok  <= fall_w & high_sat;              // long idle before
      end
    end

  end

endmodule

// File: hw/ctrl_line_if.sv
// per-port line events from the timer to a frame sniffer
// edge strobes, decided bit, idle gap flag, timeout level
`timescale 1ns/1ps

interface ctrl_line_if;

  logic fall;     // synchronized falling edge, one cycle
  logic rise;     // synchronized rising edge, one cycle
  logic bit_val;  // decided bit, valid with fall
  logic gap_ok;   // high time before this fall was saturated
  logic timeout;  // level, a counter sits at saturation

  // timer side
  modport timer (
    output fall,
    output rise,
    output bit_val,
    output gap_ok,
    output timeout
  );

  // sniffer side
  modport sniffer (
    input fall,
    input rise,
    input bit_val,
    input gap_ok,
    input timeout
  );

endinterface

// File: hw/n64_ctrl_pkg.sv
// shared definitions for the joybus controller monitor
// widths, line timing limits, frame lengths, reset combination
// and the sniffer FSM states
package n64_ctrl_pkg;

  ////////////////////
  // ports and widths
  ////////////////////
  localparam int unsigned NUM_PORTS = 4;   // controller ports on the console

  typedef logic [7:0]  cnt_t;       // line duration counter, saturating
  typedef logic [7:0]  cmd_t;       // console command byte
  typedef logic [31:0] ctrl_word_t; // controller response, bit i = i-th bit on the wire
  typedef logic [15:0] btn_t;       // button field, low half of the response
  typedef logic [1:0]  port_t;      // port index
  typedef logic [4:0]  bit_cnt_t;   // bit position inside a command or response

  ////////////////////
  // joybus framing
  ////////////////////
  localparam cnt_t GAP_CYCLES = 8'd255;  // idle before a frame, also in-frame timeout
  localparam cmd_t POLL_CMD   = 8'h01;   // status poll, msb first on the line

  localparam int unsigned CMD_BITS  = 8;
  localparam int unsigned RESP_BITS = 32;

  // in-game reset combination: Z + Start + L + R
  // bit 2 Z, bit 3 Start, bit 10 L, bit 11 R
  localparam btn_t IGR_COMBO = 16'h0C0C;

  ////////////////////
  // reset pulse
  ////////////////////
  localparam int unsigned RST_HOLD_CYCLES = 1000;  // console reset low time
  localparam int unsigned RST_CNT_W       = $clog2(RST_HOLD_CYCLES + 1);

  typedef logic [RST_CNT_W-1:0] rst_cnt_t;

  // frame sniffer states
  typedef enum logic [1:0] {
    st_idle,  // waiting for a fall after a long idle
    st_cmd,   // command byte from the console
    st_skip,  // console stop bit
    st_resp   // 32 response bits from the controller
  } sniff_state_t;

endpackage
